/* motor_ctrl_pkg.sv */
// Shared widths, types, command codes and frame layout for the motor board RTL
`default_nettype none

package motor_ctrl_pkg;

    // Motor channels on the board
    localparam int NUM_MOTORS = 4;

    // Field widths
    localparam int BYTE_W = 8;
    localparam int DUTY_W = 10;
    localparam int ENC_W  = 16;

    typedef logic [BYTE_W-1:0] byte_t;
    typedef logic [DUTY_W-1:0] duty_t;
    typedef logic [ENC_W-1:0]  enc_count_t;

    // Bit order is {a, b, c}, phase a in the MSB
    typedef logic [2:0] phase_t;
    typedef logic [2:0] hall_t;

    // Low seven bits of byte 0, the MSB is the read flag
    typedef logic [6:0] cmd_t;

    localparam cmd_t CMD_UPDATE_MTRS     = 7'h00;
    localparam cmd_t CMD_ENCODER_COUNT   = 7'h11;
    localparam cmd_t CMD_DUTY_CYCLE      = 7'h13;
    localparam cmd_t CMD_TOGGLE_MOTOR_EN = 7'h30;

    // Returned for reads nobody decodes
    localparam byte_t RES_FILL = 8'hAA;

    // Command byte, eight duty/count bytes, one watchdog byte
    localparam int BUF_LEN = 10;
    typedef logic [3:0] buf_idx_t;

    // One tick per 16 cycles, 256 ticks to expire
    localparam int WDT_PRESCALE_W = 4;
    localparam int WDT_W          = 8;
    typedef logic [WDT_W-1:0] wdt_count_t;

endpackage

`default_nettype wire

/* spi_byte_if.sv */
// Byte-level handshake between the SPI slave port and the command controller
`timescale 1ns/1ns
`default_nettype none

interface spi_byte_if import motor_ctrl_pkg::*; ();

    // Single-cycle pulses from the port
    logic  frame_start;
    logic  frame_end;
    logic  byte_done;
    // Received byte, valid with byte_done
    byte_t rx_byte;
    // Next byte to shift out, held as a level by the controller
    byte_t tx_byte;

    modport port (
        output frame_start, frame_end, byte_done, rx_byte,
        input  tx_byte
    );

    modport ctrl (
        input  frame_start, frame_end, byte_done, rx_byte,
        output tx_byte
    );

endinterface

`default_nettype wire

/* spi_slave_port.sv */
// Mode 0 SPI slave that turns the host pins into byte pulses for the command controller
`timescale 1ns/1ns
`default_nettype none

module spi_slave_port import motor_ctrl_pkg::*; (
    input  logic     sysclk,
    input  logic     watchdog_timer_reset_flag,
    input  logic     spi_sck_i,
    input  logic     spi_mosi_i,
    input  logic     spi_ncs_i,
    output logic     spi_miso_o,
    output logic     spi_miso_oe_o,
    spi_byte_if.port bus
);

    // Two sync stages plus one history stage for edge detection
    logic [2:0] sck_sync;
    logic [2:0] ncs_sync;
    logic [1:0] mosi_sync;
    logic       sck_rise;
    logic       sck_fall;
    logic       ncs_fall;
    logic       ncs_rise;
    logic       selected;
    logic [2:0] bit_cnt;
    logic [6:0] rx_shift;
    byte_t      tx_shift;

    assign sck_rise = sck_sync[1] & ~sck_sync[2];
    assign sck_fall = ~sck_sync[1] & sck_sync[2];
    assign ncs_fall = ~ncs_sync[1] & ncs_sync[2];
    assign ncs_rise = ncs_sync[1] & ~ncs_sync[2];
    assign selected = ~ncs_sync[1];

    always_ff @(posedge sysclk) begin
        if (watchdog_timer_reset_flag) begin
            sck_sync  <= '0;
            // Idle deselected so reset cannot fake a frame start
            ncs_sync  <= '1;
            mosi_sync <= '0;
        end else begin
            sck_sync  <= {sck_sync[1:0], spi_sck_i};
            ncs_sync  <= {ncs_sync[1:0], spi_ncs_i};
            mosi_sync <= {mosi_sync[0], spi_mosi_i};
        end
    end

    // Frame pulses and bit counting
    always_ff @(posedge sysclk) begin
        if (watchdog_timer_reset_flag) begin
            bit_cnt         <= '0;
            bus.frame_start <= 1'b0;
            bus.frame_end   <= 1'b0;
            bus.byte_done   <= 1'b0;
        end else begin
            bus.frame_start <= ncs_fall;
            bus.frame_end   <= ncs_rise;
            bus.byte_done   <= selected && sck_rise && (bit_cnt == 3'd7);
            if (ncs_fall) begin
                bit_cnt <= '0;
            end else if (selected && sck_rise) begin
                // Wraps to 0 after the eighth bit
                bit_cnt <= bit_cnt + 3'd1;
            end
        end
    end

    // Data shifters
    always_ff @(posedge sysclk) begin
        if (selected && sck_rise) begin
            rx_shift <= {rx_shift[5:0], mosi_sync[1]};
            if (bit_cnt == 3'd7) begin
                bus.rx_byte <= {rx_shift, mosi_sync[1]};
            end
        end
        if (selected && sck_fall) begin
            // First fall of a byte: take the remaining seven bits of tx_byte
            if (bit_cnt == 3'd1) begin
                tx_shift <= {bus.tx_byte[6:0], 1'b0};
            end else begin
                tx_shift <= {tx_shift[6:0], 1'b0};
            end
        end
    end

    // MSB is presented straight from tx_byte so it is ready before the first rise
    assign spi_miso_o    = (bit_cnt == 3'd0) ? bus.tx_byte[7] : tx_shift[7];
    assign spi_miso_oe_o = selected;

endmodule

`default_nettype wire

/* cmd_ctrl.sv */
// Command decoder holding the SPI request/response buffers, duty registers and motor enable
`timescale 1ns/1ns
`default_nettype none

module cmd_ctrl import motor_ctrl_pkg::*; (
    input  logic                  sysclk,
    input  logic                  watchdog_timer_reset_flag,
    input  enc_count_t            enc_count_i [NUM_MOTORS],
    input  logic [NUM_MOTORS-1:0] hall_error_i,
    input  logic                  wdt_tripped_i,
    input  wdt_count_t            wdt_count_i,
    output duty_t                 duty_o [NUM_MOTORS],
    output logic                  motors_run_o,
    output logic                  enc_clear_o,
    output logic                  wdt_kick_o,
    spi_byte_if.ctrl              bus
);

    byte_t    req_buf [BUF_LEN];
    // Slot 0 is the live status byte, so the buffer starts at 1
    byte_t    res_buf [1:BUF_LEN-1];
    buf_idx_t byte_cnt;
    logic     motors_en;
    logic     cmd_done;
    logic     rx_read;
    cmd_t     rx_cmd;
    logic     update_cmd;
    logic     frame_read;
    cmd_t     frame_cmd;
    byte_t    status;

    // Command fields straight off the wire, used on byte 0
    assign rx_read    = bus.rx_byte[7];
    assign rx_cmd     = bus.rx_byte[6:0];
    assign cmd_done   = bus.byte_done && (byte_cnt == '0);
    assign update_cmd = cmd_done && rx_read && (rx_cmd == CMD_UPDATE_MTRS);

    // Stored command fields, used at frame end
    assign frame_read = req_buf[0][7];
    assign frame_cmd  = req_buf[0][6:0];

    assign status = {wdt_tripped_i, motors_en, 2'b00, hall_error_i};

    // Byte index, cleared on both frame edges so idle points at status
    always_ff @(posedge sysclk) begin
        if (watchdog_timer_reset_flag) begin
            byte_cnt <= '0;
        end else if (bus.frame_start || bus.frame_end) begin
            byte_cnt <= '0;
        end else if (bus.byte_done && (byte_cnt != '1)) begin
            // Saturate on runaway frames
            byte_cnt <= byte_cnt + 1'b1;
        end
    end

    // Request capture
    always_ff @(posedge sysclk) begin
        if (bus.byte_done && (byte_cnt < BUF_LEN)) begin
            req_buf[byte_cnt] <= bus.rx_byte;
        end
    end

    // Response load on the command byte
    always_ff @(posedge sysclk) begin
        if (cmd_done) begin
            if (rx_read && (rx_cmd == CMD_UPDATE_MTRS || rx_cmd == CMD_ENCODER_COUNT)) begin
                // Counts latched here, cleared a cycle later by enc_clear
                for (int m = 0; m < NUM_MOTORS; m++) begin
                    res_buf[2*m+1] <= enc_count_i[m][ENC_W-1:BYTE_W];
                    res_buf[2*m+2] <= enc_count_i[m][BYTE_W-1:0];
                end
                res_buf[BUF_LEN-1] <= wdt_count_i;
            end else if (rx_read && (rx_cmd == CMD_DUTY_CYCLE)) begin
                // High byte first, zero extended
                for (int m = 0; m < NUM_MOTORS; m++) begin
                    res_buf[2*m+1] <= byte_t'(duty_o[m] >> BYTE_W);
                    res_buf[2*m+2] <= duty_o[m][BYTE_W-1:0];
                end
                res_buf[BUF_LEN-1] <= '0;
            end else begin
                for (int i = 1; i < BUF_LEN; i++) begin
                    res_buf[i] <= RES_FILL;
                end
            end
        end
    end

    // Update read kicks the watchdog and restarts the encoder spans
    always_ff @(posedge sysclk) begin
        if (watchdog_timer_reset_flag) begin
            wdt_kick_o  <= 1'b0;
            enc_clear_o <= 1'b0;
        end else begin
            wdt_kick_o  <= update_cmd;
            enc_clear_o <= update_cmd;
        end
    end

    // Frame end actions, a trip overrides them
    always_ff @(posedge sysclk) begin
        if (watchdog_timer_reset_flag) begin
            motors_en <= 1'b1;
            for (int m = 0; m < NUM_MOTORS; m++) begin
                duty_o[m] <= '0;
            end
        end else if (wdt_tripped_i) begin
            motors_en <= 1'b0;
        end else if (bus.frame_end) begin
            // Full update frame only, duties arrive low byte first
            if (frame_read && (frame_cmd == CMD_UPDATE_MTRS) && (byte_cnt == BUF_LEN - 1)) begin
                for (int m = 0; m < NUM_MOTORS; m++) begin
                    duty_o[m] <= {req_buf[2*m+2][DUTY_W-BYTE_W-1:0], req_buf[2*m+1]};
                end
                motors_en <= 1'b1;
            end
            // Toggle in a one-byte frame, read form enables
            if ((frame_cmd == CMD_TOGGLE_MOTOR_EN) && (byte_cnt == buf_idx_t'(1))) begin
                motors_en <= frame_read;
            end
        end
    end

    // Outgoing byte by position in the frame
    always_comb begin
        if (byte_cnt == '0) begin
            bus.tx_byte = status;
        end else if (byte_cnt < BUF_LEN) begin
            bus.tx_byte = res_buf[byte_cnt];
        end else begin
            bus.tx_byte = RES_FILL;
        end
    end

    assign motors_run_o = motors_en & ~wdt_tripped_i;

endmodule

`default_nettype wire

/* watchdog.sv */
// Timeout that trips when the host stops sending motor updates, restarted by a kick
`timescale 1ns/1ns
`default_nettype none

module watchdog import motor_ctrl_pkg::*; (
    input  logic       sysclk,
    input  logic       watchdog_timer_reset_flag,
    input  logic       wdt_kick_i,
    output logic       wdt_tripped_o,
    output wdt_count_t wdt_count_o
);

    logic [WDT_PRESCALE_W-1:0] prescale;
    logic                      tick;

    // One tick on each prescaler wrap
    assign tick = &prescale;

    always_ff @(posedge sysclk) begin
        if (watchdog_timer_reset_flag) begin
            prescale      <= '0;
            wdt_count_o   <= '0;
            wdt_tripped_o <= 1'b0;
        end else if (wdt_kick_i) begin
            // Restart the full period
            prescale      <= '0;
            wdt_count_o   <= '0;
            wdt_tripped_o <= 1'b0;
        end else begin
            prescale <= prescale + 1'b1;
            if (tick) begin
                // Overflow trips, count wraps and keeps going
                if (&wdt_count_o) begin
                    wdt_tripped_o <= 1'b1;
                end
                wdt_count_o <= wdt_count_o + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* quad_encoder.sv */
// x4 quadrature decoder for one motor encoder, keeps a wrapping 16-bit position
`timescale 1ns/1ns
`default_nettype none

module quad_encoder import motor_ctrl_pkg::*; (
    input  logic       sysclk,
    input  logic       watchdog_timer_reset_flag,
    input  logic       enc_a_i,
    input  logic       enc_b_i,
    input  logic       clear_i,
    output enc_count_t count_o
);

    // {a, b} through two sync stages and one history stage
    logic [1:0] ab_s1;
    logic [1:0] ab_s2;
    logic [1:0] ab_prev;

    always_ff @(posedge sysclk) begin
        if (watchdog_timer_reset_flag) begin
            ab_s1   <= '0;
            ab_s2   <= '0;
            ab_prev <= '0;
            count_o <= '0;
        end else begin
            ab_s1   <= {enc_a_i, enc_b_i};
            ab_s2   <= ab_s1;
            ab_prev <= ab_s2;
            if (clear_i) begin
                count_o <= '0;
            end else begin
                case ({ab_prev, ab_s2})
                    // A leads B
                    4'b00_10, 4'b10_11, 4'b11_01, 4'b01_00: count_o <= count_o + 1'b1;
                    // B leads A
                    4'b00_01, 4'b01_11, 4'b11_10, 4'b10_00: count_o <= count_o - 1'b1;
                    // No change or an illegal double step
                    default: count_o <= count_o;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* bldc_commutator.sv */
// Six-step hall commutation with PWM on the high side for one brushless motor
`timescale 1ns/1ns
`default_nettype none

module bldc_commutator import motor_ctrl_pkg::*; (
    input  logic   sysclk,
    input  logic   watchdog_timer_reset_flag,
    input  hall_t  hall_i,
    input  duty_t  duty_i,
    input  logic   run_i,
    output phase_t phase_h_o,
    output phase_t phase_l_o,
    output logic   hall_error_o
);

    duty_t  pwm_cnt;
    // First pipeline stage
    hall_t  hall_s;
    logic   pwm_on;
    logic   run_s;
    // Table lookup
    phase_t src;
    phase_t sink;
    logic   hall_valid;

    always_ff @(posedge sysclk) begin
        if (watchdog_timer_reset_flag) begin
            pwm_cnt <= '0;
            hall_s  <= '0;
            pwm_on  <= 1'b0;
            run_s   <= 1'b0;
        end else begin
            pwm_cnt <= pwm_cnt + 1'b1;
            hall_s  <= hall_i;
            // Duty cycles on per 1024-cycle period
            pwm_on  <= pwm_cnt < duty_i;
            run_s   <= run_i;
        end
    end

    // Sourcing and sinking phase per hall state
    always_comb begin
        hall_valid = 1'b1;
        case (hall_s)
            3'b001: begin src = 3'b100; sink = 3'b010; end
            3'b011: begin src = 3'b100; sink = 3'b001; end
            3'b010: begin src = 3'b010; sink = 3'b001; end
            3'b110: begin src = 3'b010; sink = 3'b100; end
            3'b100: begin src = 3'b001; sink = 3'b100; end
            3'b101: begin src = 3'b001; sink = 3'b010; end
            default: begin
                // 000 and 111 are sensor faults
                src        = 3'b000;
                sink       = 3'b000;
                hall_valid = 1'b0;
            end
        endcase
    end

    // Registered drive, two cycles behind the inputs
    always_ff @(posedge sysclk) begin
        if (watchdog_timer_reset_flag) begin
            phase_h_o    <= '0;
            phase_l_o    <= '0;
            hall_error_o <= 1'b0;
        end else begin
            phase_h_o    <= (run_s && pwm_on) ? src : '0;
            phase_l_o    <= run_s ? sink : '0;
            hall_error_o <= ~hall_valid;
        end
    end

endmodule

`default_nettype wire

/* motor_board_top.sv */
// Motor board top: SPI command path, watchdog and four motor channels
`timescale 1ns/1ns
`default_nettype none

module motor_board_top import motor_ctrl_pkg::*; (
    input  logic                  sysclk,
    input  logic                  watchdog_timer_reset_flag,
    input  logic                  spi_sck_i,
    input  logic                  spi_mosi_i,
    input  logic                  spi_ncs_i,
    input  logic [NUM_MOTORS-1:0] hall_a_i,
    input  logic [NUM_MOTORS-1:0] hall_b_i,
    input  logic [NUM_MOTORS-1:0] hall_c_i,
    input  logic [NUM_MOTORS-1:0] enc_a_i,
    input  logic [NUM_MOTORS-1:0] enc_b_i,
    output logic                  spi_miso_o,
    output logic                  spi_miso_oe_o,
    output phase_t                phase_h_o [NUM_MOTORS],
    output phase_t                phase_l_o [NUM_MOTORS]
);

    enc_count_t            enc_count [NUM_MOTORS];
    duty_t                 duty [NUM_MOTORS];
    logic [NUM_MOTORS-1:0] hall_error;
    logic                  motors_run;
    logic                  enc_clear;
    logic                  wdt_kick;
    logic                  wdt_tripped;
    wdt_count_t            wdt_count;

    spi_byte_if spi_bus ();

    spi_slave_port u_spi_port (
        .sysclk                    (sysclk),
        .watchdog_timer_reset_flag (watchdog_timer_reset_flag),
        .spi_sck_i                 (spi_sck_i),
        .spi_mosi_i                (spi_mosi_i),
        .spi_ncs_i                 (spi_ncs_i),
        .spi_miso_o                (spi_miso_o),
        .spi_miso_oe_o             (spi_miso_oe_o),
        .bus                       (spi_bus.port)
    );

    cmd_ctrl u_cmd_ctrl (
        .sysclk                    (sysclk),
        .watchdog_timer_reset_flag (watchdog_timer_reset_flag),
        .enc_count_i               (enc_count),
        .hall_error_i              (hall_error),
        .wdt_tripped_i             (wdt_tripped),
        .wdt_count_i               (wdt_count),
        .duty_o                    (duty),
        .motors_run_o              (motors_run),
        .enc_clear_o               (enc_clear),
        .wdt_kick_o                (wdt_kick),
        .bus                       (spi_bus.ctrl)
    );

    watchdog u_watchdog (
        .sysclk                    (sysclk),
        .watchdog_timer_reset_flag (watchdog_timer_reset_flag),
        .wdt_kick_i                (wdt_kick),
        .wdt_tripped_o             (wdt_tripped),
        .wdt_count_o               (wdt_count)
    );

    // One encoder and one commutator per motor
    for (genvar m = 0; m < NUM_MOTORS; m++) begin : g_motor
        quad_encoder u_encoder (
            .sysclk                    (sysclk),
            .watchdog_timer_reset_flag (watchdog_timer_reset_flag),
            .enc_a_i                   (enc_a_i[m]),
            .enc_b_i                   (enc_b_i[m]),
            .clear_i                   (enc_clear),
            .count_o                   (enc_count[m])
        );

        bldc_commutator u_commutator (
            .sysclk                    (sysclk),
            .watchdog_timer_reset_flag (watchdog_timer_reset_flag),
            .hall_i                    ({hall_a_i[m], hall_b_i[m], hall_c_i[m]}),
            .duty_i                    (duty[m]),
            .run_i                     (motors_run),
            .phase_h_o                 (phase_h_o[m]),
            .phase_l_o                 (phase_l_o[m]),
            .hall_error_o              (hall_error[m])
        );
    end

endmodule

`default_nettype wire

/* tb_spi_tasks.svh */
// Testbench tasks that bit-bang SPI frames and compare typed results, included by the testbench top
`ifndef TB_SPI_TASKS_SVH
`define TB_SPI_TASKS_SVH

    // Inputs change 2 ns after the rising edge
    task automatic step_cycles(input int n);
        repeat (n) begin
            @(posedge sysclk);
        end
        #2;
    endtask

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_byte(input string name, input byte_t exp, input byte_t act);
        if (exp !== act) begin
            fail_run($sformatf("error %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_phase(input string name, input phase_t exp, input phase_t act);
        if (exp !== act) begin
            fail_run($sformatf("error %s expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic check_duty_count(input string name, input duty_t exp, input duty_t act);
        if (exp !== act) begin
            fail_run($sformatf("error %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    // Mode 0 frame of n bytes from tx_buf with MISO captured into rx_buf
    // Half period of 8 cycles with MISO sampled just before each rising SCK
    task automatic spi_frame(input int n);
        byte_t rx;
        spi_ncs = 1'b0;
        step_cycles(8);
        for (int i = 0; i < n; i++) begin
            rx = '0;
            for (int b = 7; b >= 0; b--) begin
                spi_mosi = tx_buf[i][b];
                step_cycles(8);
                if (spi_miso_oe !== 1'b1) begin
                    fail_run("MISO enable was low while chip select was active");
                end
                rx = {rx[6:0], spi_miso};
                spi_sck = 1'b1;
                // Last bit of an update command byte restarts the watchdog
                if (i == 0 && b == 0 && tx_buf[0] == 8'h80) begin
                    kick_cycle = cycle_cnt;
                end
                step_cycles(8);
                spi_sck = 1'b0;
            end
            rx_buf[i] = rx;
        end
        step_cycles(8);
        spi_ncs = 1'b1;
        step_cycles(12);
        if (spi_miso_oe !== 1'b0) begin
            fail_run("MISO enable stayed high after chip select was released");
        end
    endtask

`endif

/* tb_motor_board.sv */
// Testbench that runs SPI frames, encoder steps and hall codes on the motor board against a model
`timescale 1ns/1ns
`default_nettype none

module tb_motor_board import motor_ctrl_pkg::*; ();

    // Worst-case run length in cycles with a 20% margin
    // Each SPI byte takes 128 cycles and each frame adds up to 40 cycles of select time
    localparam int FRAME_BYTES  = 131;
    localparam int FRAME_COUNT  = 21;
    localparam int ENC_STEPS    = 40;
    localparam int HALL_ROUNDS  = 3;
    localparam int WDT_WAIT     = 4200;
    localparam int CYCLE_LIMIT  = (FRAME_BYTES * 128 + FRAME_COUNT * 40 + ENC_STEPS * 8
                                   + HALL_ROUNDS * 1100 + WDT_WAIT + 10) * 12 / 10;
    localparam hall_t VALID_HALLS [6] = '{3'b001, 3'b011, 3'b010, 3'b110, 3'b100, 3'b101};

    logic                  sysclk;
    logic                  watchdog_timer_reset_flag;
    logic                  spi_sck;
    logic                  spi_mosi;
    logic                  spi_ncs;
    logic                  spi_miso;
    logic                  spi_miso_oe;
    logic [NUM_MOTORS-1:0] hall_a;
    logic [NUM_MOTORS-1:0] hall_b;
    logic [NUM_MOTORS-1:0] hall_c;
    logic [NUM_MOTORS-1:0] enc_a;
    logic [NUM_MOTORS-1:0] enc_b;
    phase_t                phase_h [NUM_MOTORS];
    phase_t                phase_l [NUM_MOTORS];

    // Reference model state
    duty_t                 m_duty [NUM_MOTORS];
    logic                  m_en;
    logic                  m_trip;
    logic [NUM_MOTORS-1:0] m_herr;
    // Net encoder steps since the last update command
    enc_count_t            m_net [NUM_MOTORS];
    logic [1:0]            m_ab [NUM_MOTORS];
    hall_t                 m_hall [NUM_MOTORS];

    // Frame buffers shared with the SPI task
    byte_t tx_buf [BUF_LEN];
    byte_t rx_buf [BUF_LEN];
    int    seed;
    int    cycle_cnt;
    // Cycle of the last SCK rise that ends an update command byte
    int    kick_cycle;

    motor_board_top motor_board_top_i (
        .sysclk                    (sysclk),
        .watchdog_timer_reset_flag (watchdog_timer_reset_flag),
        .spi_sck_i                 (spi_sck),
        .spi_mosi_i                (spi_mosi),
        .spi_ncs_i                 (spi_ncs),
        .hall_a_i                  (hall_a),
        .hall_b_i                  (hall_b),
        .hall_c_i                  (hall_c),
        .enc_a_i                   (enc_a),
        .enc_b_i                   (enc_b),
        .spi_miso_o                (spi_miso),
        .spi_miso_oe_o             (spi_miso_oe),
        .phase_h_o                 (phase_h),
        .phase_l_o                 (phase_l)
    );

    `include "tb_spi_tasks.svh"

    always #10 sysclk = ~sysclk;

    // Cycle counter doubles as the run limit
    always @(posedge sysclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            fail_run("simulation ran past its cycle limit");
        end
    end

    // Status layout from MSB down is trip, enable, two zeros, hall errors
    function automatic byte_t exp_status();
        return {m_trip, m_en, 2'b00, m_herr};
    endfunction

    // Sourcing phase per hall code with phase a in the MSB
    function automatic phase_t hall_src(input hall_t h);
        case (h)
            3'b001, 3'b011: return 3'b100;
            3'b010, 3'b110: return 3'b010;
            3'b100, 3'b101: return 3'b001;
            default:        return 3'b000;
        endcase
    endfunction

    // Sinking phase per hall code
    function automatic phase_t hall_sink(input hall_t h);
        case (h)
            3'b001, 3'b101: return 3'b010;
            3'b011, 3'b010: return 3'b001;
            3'b110, 3'b100: return 3'b100;
            default:        return 3'b000;
        endcase
    endfunction

    // Gray order 00, 10, 11, 01 counts up
    function automatic logic [1:0] gray_next(input logic [1:0] s, input logic up);
        case (s)
            2'b00:   return up ? 2'b10 : 2'b01;
            2'b10:   return up ? 2'b11 : 2'b00;
            2'b11:   return up ? 2'b01 : 2'b10;
            default: return up ? 2'b00 : 2'b11;
        endcase
    endfunction

    // Model hall and encoder state onto the pins
    task automatic drive_pins();
        for (int m = 0; m < NUM_MOTORS; m++) begin
            hall_a[m] = m_hall[m][2];
            hall_b[m] = m_hall[m][1];
            hall_c[m] = m_hall[m][0];
            enc_a[m]  = m_ab[m][1];
            enc_b[m]  = m_ab[m][0];
        end
    endtask

    // Full update returns status and counts since the last update, then new duties apply
    task automatic update_frame(input string name);
        tx_buf[0] = 8'h80;
        // Duties go out low byte first
        for (int m = 0; m < NUM_MOTORS; m++) begin
            tx_buf[2*m+1] = m_duty[m][7:0];
            tx_buf[2*m+2] = {6'b0, m_duty[m][9:8]};
        end
        spi_frame(9);
        check_byte({name, " status"}, exp_status(), rx_buf[0]);
        for (int m = 0; m < NUM_MOTORS; m++) begin
            check_byte({name, " count hi"}, m_net[m][15:8], rx_buf[2*m+1]);
            check_byte({name, " count lo"}, m_net[m][7:0], rx_buf[2*m+2]);
            m_net[m] = '0;
        end
        // The kick clears a trip and the full frame enables the motors
        m_trip = 1'b0;
        m_en   = 1'b1;
    endtask

    // Duty readback comes high byte first
    task automatic read_duty(input string name);
        tx_buf[0] = 8'h93;
        for (int i = 1; i < BUF_LEN; i++) begin
            tx_buf[i] = 8'h00;
        end
        spi_frame(9);
        check_byte({name, " status"}, exp_status(), rx_buf[0]);
        for (int m = 0; m < NUM_MOTORS; m++) begin
            check_byte({name, " duty hi"}, {6'b0, m_duty[m][9:8]}, rx_buf[2*m+1]);
            check_byte({name, " duty lo"}, m_duty[m][7:0], rx_buf[2*m+2]);
        end
    endtask

    // One-byte unknown read that checks only the status byte
    task automatic status_frame(input string name);
        tx_buf[0] = 8'hFF;
        spi_frame(1);
        check_byte({name, " status"}, exp_status(), rx_buf[0]);
    endtask

    task automatic check_all_off(input string name);
        for (int m = 0; m < NUM_MOTORS; m++) begin
            check_phase({name, " high"}, 3'b000, phase_h[m]);
            check_phase({name, " low"}, 3'b000, phase_l[m]);
        end
    endtask

    // Low sides stay on while the motors run, independent of PWM
    task automatic check_low_sides(input string name);
        for (int m = 0; m < NUM_MOTORS; m++) begin
            check_phase({name, " low"}, hall_sink(m_hall[m]), phase_l[m]);
        end
    endtask

    task automatic randomize_duties();
        for (int m = 0; m < NUM_MOTORS; m++) begin
            m_duty[m] = duty_t'($random(seed));
        end
    endtask

    initial begin
        duty_t on_cnt [NUM_MOTORS];
        int    k;
        sysclk                    = 1'b0;
        watchdog_timer_reset_flag = 1'b1;
        spi_sck                   = 1'b0;
        spi_mosi                  = 1'b0;
        spi_ncs                   = 1'b1;
        seed                      = 66581;
        cycle_cnt                 = 0;
        kick_cycle                = 0;
        m_en                      = 1'b1;
        m_trip                    = 1'b0;
        m_herr                    = '0;
        for (int m = 0; m < NUM_MOTORS; m++) begin
            m_duty[m] = '0;
            m_net[m]  = '0;
            m_ab[m]   = 2'b00;
            m_hall[m] = 3'b001;
        end
        drive_pins();
        step_cycles(10);
        watchdog_timer_reset_flag = 1'b0;
        step_cycles(4);

        // Reset state and the fill byte
        read_duty("reset duty read");
        tx_buf[0] = 8'hFF;
        spi_frame(10);
        check_byte("unknown read status", exp_status(), rx_buf[0]);
        for (int i = 1; i < BUF_LEN; i++) begin
            check_byte("unknown read fill", RES_FILL, rx_buf[i]);
        end

        // Duty write and readback
        randomize_duties();
        update_frame("duty write");
        read_duty("duty readback");
        // Short update frame must leave the duties alone
        tx_buf[0] = 8'h80;
        for (int i = 1; i < 6; i++) begin
            tx_buf[i] = byte_t'($random(seed));
        end
        spi_frame(6);
        // Its command byte still clears the encoder spans
        for (int m = 0; m < NUM_MOTORS; m++) begin
            m_net[m] = '0;
        end
        read_duty("short update readback");

        // Encoder steps counted in the next update response
        update_frame("encoder clear");
        repeat (ENC_STEPS) begin
            for (int m = 0; m < NUM_MOTORS; m++) begin
                k = $random(seed) & 1;
                m_ab[m]  = gray_next(m_ab[m], k[0]);
                m_net[m] = k[0] ? m_net[m] + 16'd1 : m_net[m] - 16'd1;
            end
            drive_pins();
            // Each state held longer than the 4-cycle minimum
            step_cycles(5);
        end
        step_cycles(8);
        update_frame("encoder counts");

        // Commutation table and PWM on-time over one full period
        repeat (HALL_ROUNDS) begin
            randomize_duties();
            for (int m = 0; m < NUM_MOTORS; m++) begin
                m_hall[m] = VALID_HALLS[$unsigned($random(seed)) % 6];
                on_cnt[m] = '0;
            end
            drive_pins();
            update_frame("hall update");
            step_cycles(6);
            // 1024 cycles cover one PWM period from any start point
            repeat (1024) begin
                for (int m = 0; m < NUM_MOTORS; m++) begin
                    if (phase_h[m] != 3'b000) begin
                        check_phase("pwm high", hall_src(m_hall[m]), phase_h[m]);
                        on_cnt[m] = on_cnt[m] + 1'b1;
                    end
                    check_phase("pwm low", hall_sink(m_hall[m]), phase_l[m]);
                end
                step_cycles(1);
            end
            for (int m = 0; m < NUM_MOTORS; m++) begin
                check_duty_count("pwm on cycles", m_duty[m], on_cnt[m]);
            end
        end
        // One motor gets a faulty hall code
        k = $unsigned($random(seed)) % NUM_MOTORS;
        m_hall[k] = ($random(seed) & 1) ? 3'b111 : 3'b000;
        m_herr[k] = 1'b1;
        drive_pins();
        step_cycles(6);
        check_phase("invalid hall high", 3'b000, phase_h[k]);
        check_phase("invalid hall low", 3'b000, phase_l[k]);
        status_frame("invalid hall");
        m_hall[k] = 3'b010;
        m_herr[k] = 1'b0;
        drive_pins();
        step_cycles(6);

        // Enable toggle
        update_frame("toggle setup");
        tx_buf[0] = 8'h30;
        spi_frame(1);
        m_en = 1'b0;
        step_cycles(4);
        check_all_off("toggle off");
        status_frame("toggle off");
        tx_buf[0] = 8'hB0;
        spi_frame(1);
        m_en = 1'b1;
        step_cycles(4);
        check_low_sides("toggle on");

        // Watchdog expiry and recovery
        update_frame("watchdog start");
        // Status bit 7 is sampled 16 cycles into the frame, about 4000 cycles after the kick
        while (cycle_cnt - kick_cycle < 3984) begin
            step_cycles(1);
        end
        status_frame("watchdog before expiry");
        while (cycle_cnt - kick_cycle < WDT_WAIT) begin
            step_cycles(1);
        end
        m_trip = 1'b1;
        m_en   = 1'b0;
        check_all_off("watchdog tripped");
        status_frame("watchdog tripped");
        update_frame("watchdog recover");
        step_cycles(4);
        status_frame("watchdog cleared");
        check_low_sides("watchdog cleared");

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+.
motor_ctrl_pkg.sv
spi_byte_if.sv
spi_slave_port.sv
cmd_ctrl.sv
watchdog.sv
quad_encoder.sv
bldc_commutator.sv
motor_board_top.sv
tb_motor_board.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the motor board testbench with Verilator

verilator --binary --timing -f vlog.f --top-module tb_motor_board -Mdir obj_dir -o tb_motor_board
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_motor_board > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "all tests passed" sim.log; then
    exit 0
else
    exit 1
fi
